// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// datapath and address width
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs = 32;

	// pc step per instruction
	localparam logic [xlen-1:0] instr_bytes = 4;

	// memory mapped switches on load, leds on store
	localparam logic [xlen-1:0] io_addr = 32'h0000_A000;
	localparam int led_w = 8;

	// major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		op     = 7'b0110011,
		op_imm = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		branch = 7'b1100011,
		lui    = 7'b0110111
	} opcode_e;

	// multicycle sequence
	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem,
		st_dest
	} core_state_e;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] funct3;
		// instr bit 30, sub and sra
		logic alt;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		// sign extended, format picked by opcode
		logic [xlen-1:0] imm;
	} decoded_t;

	typedef struct packed {
		logic [xlen-1:0] rs1_val;
		logic [xlen-1:0] rs2_val;
	} operands_t;

	typedef struct packed {
		logic taken;
		logic [xlen-1:0] target;
	} branch_t;

endpackage

`default_nettype wire

// ==== core/rv_decode.sv ====
`default_nettype none

module rv_decode (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    i_load_ir,
	input  wire logic [rv_pkg::xlen-1:0] i_instr,
	output rv_pkg::decoded_t             o_dec
);

	// instruction register
	logic [rv_pkg::xlen-1:0] ir;
	rv_pkg::opcode_e opcode;

	// loaded at the edge that ends fetch, held until the next fetch
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (i_load_ir) begin
			ir <= i_instr;
		end
	end

	assign opcode = rv_pkg::opcode_e'(ir[6:0]);

	// fields sit at fixed positions for every format
	always_comb begin
		o_dec.opcode = opcode;
		o_dec.funct3 = ir[14:12];
		o_dec.alt = ir[30];
		o_dec.rd = ir[11:7];
		o_dec.rs1 = ir[19:15];
		o_dec.rs2 = ir[24:20];
		// immediate by format
		case (opcode)
			// I type
			rv_pkg::op_imm, rv_pkg::load: begin
				o_dec.imm = {{20{ir[31]}}, ir[31:20]};
			end
			// S type, split field
			rv_pkg::store: begin
				o_dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			end
			// B type, bit 0 always zero
			rv_pkg::branch: begin
				o_dec.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			end
			// U type
			rv_pkg::lui: begin
				o_dec.imm = {ir[31:12], 12'b0};
			end
			// R type has none
			default: begin
				o_dec.imm = '0;
			end
		endcase
	end

	// at least decode and execute sit between two fetches
	a_ir_spacing: assert property (@(posedge clk) disable iff (reset)
		i_load_ir |=> !i_load_ir);

endmodule

`default_nettype wire

// ==== core/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  rv_pkg::decoded_t             i_dec,
	input  wire logic                    i_we,
	input  wire logic [rv_pkg::xlen-1:0] i_wr_data,
	output rv_pkg::operands_t            o_ops
);

	logic [rv_pkg::xlen-1:0] regs [rv_pkg::num_regs];

	// write port, x0 never written
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < rv_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_dec.rd != '0) begin
			regs[i_dec.rd] <= i_wr_data;
		end
	end

	// async read on decoded indices
	assign o_ops.rs1_val = regs[i_dec.rs1];
	assign o_ops.rs2_val = regs[i_dec.rs2];

	// a writeback aimed at x0 leaves it zero
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		(i_we && i_dec.rd == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== core/rv_alu.sv ====
`default_nettype none

module rv_alu (
	input  rv_pkg::decoded_t             i_dec,
	input  rv_pkg::operands_t            i_ops,
	output logic [rv_pkg::xlen-1:0]      o_result
);

	logic [rv_pkg::xlen-1:0] a;
	logic [rv_pkg::xlen-1:0] b;
	logic [4:0] shamt;
	logic is_op;

	assign is_op = i_dec.opcode == rv_pkg::op;
	assign a = i_ops.rs1_val;
	// register operand for R type, immediate otherwise
	assign b = is_op ? i_ops.rs2_val : i_dec.imm;
	assign shamt = b[4:0];

	always_comb begin
		if (i_dec.opcode == rv_pkg::lui) begin
			// upper immediate passes straight through
			o_result = i_dec.imm;
		end else begin
			case (i_dec.funct3)
				// add, addi; sub only in R type
				3'd0: o_result = (is_op && i_dec.alt) ? a - b : a + b;
				3'd1: o_result = a << shamt;
				// slt, slti
				3'd2: o_result = ($signed(a) < $signed(b)) ? 1 : 0;
				// sltu, sltiu
				3'd3: o_result = (a < b) ? 1 : 0;
				3'd4: o_result = a ^ b;
				// bit 30 picks arithmetic shift for both forms
				3'd5: begin
					if (i_dec.alt) begin
						o_result = $signed(a) >>> shamt;
					end else begin
						o_result = a >> shamt;
					end
				end
				3'd6: o_result = a | b;
				default: o_result = a & b;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== core/rv_branch.sv ====
`default_nettype none

module rv_branch (
	input  rv_pkg::decoded_t             i_dec,
	input  rv_pkg::operands_t            i_ops,
	input  wire logic [rv_pkg::xlen-1:0] i_pc,
	output rv_pkg::branch_t              o_br
);

	logic cond;

	// condition by funct3
	always_comb begin
		case (i_dec.funct3)
			3'd0: cond = i_ops.rs1_val == i_ops.rs2_val;
			3'd1: cond = i_ops.rs1_val != i_ops.rs2_val;
			3'd4: cond = $signed(i_ops.rs1_val) < $signed(i_ops.rs2_val);
			3'd5: cond = $signed(i_ops.rs1_val) >= $signed(i_ops.rs2_val);
			3'd6: cond = i_ops.rs1_val < i_ops.rs2_val;
			3'd7: cond = i_ops.rs1_val >= i_ops.rs2_val;
			// 2 and 3 are not branches
			default: cond = 1'b0;
		endcase
	end

	assign o_br.taken = cond && (i_dec.opcode == rv_pkg::branch);
	// pc already stepped past this instruction
	assign o_br.target = i_pc - rv_pkg::instr_bytes + i_dec.imm;

endmodule

`default_nettype wire

// ==== core/rv_control.sv ====
`default_nettype none

module rv_control (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  rv_pkg::decoded_t             i_dec,
	input  rv_pkg::operands_t            i_ops,
	input  wire logic [rv_pkg::xlen-1:0] i_result,
	input  rv_pkg::branch_t              i_br,
	input  wire logic [rv_pkg::xlen-1:0] i_ld_data,
	output logic                         o_fetch,
	output logic [rv_pkg::xlen-1:0]      o_pc_addr,
	output logic                         o_load_ir,
	output logic                         o_ld,
	output logic                         o_st,
	output logic [rv_pkg::xlen-1:0]      o_ls_addr,
	output logic [rv_pkg::xlen-1:0]      o_st_data,
	output logic                         o_rf_we,
	output logic [rv_pkg::xlen-1:0]      o_rf_data
);

	rv_pkg::core_state_e state;
	rv_pkg::core_state_e state_nxt;
	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] result_q;
	logic [rv_pkg::xlen-1:0] ld_q;
	logic [rv_pkg::xlen-1:0] ls_addr_q;
	logic [rv_pkg::xlen-1:0] st_data_q;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic writes_rd;

	assign is_load = i_dec.opcode == rv_pkg::load;
	assign is_store = i_dec.opcode == rv_pkg::store;
	assign is_branch = i_dec.opcode == rv_pkg::branch;
	// everything kept except branch and store has a destination
	assign writes_rd = is_load || i_dec.opcode == rv_pkg::op ||
		i_dec.opcode == rv_pkg::op_imm || i_dec.opcode == rv_pkg::lui;

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			rv_pkg::st_fetch: state_nxt = rv_pkg::st_decode;
			rv_pkg::st_decode: state_nxt = rv_pkg::st_execute;
			rv_pkg::st_execute: begin
				// branches finish here
				if (is_branch) begin
					state_nxt = rv_pkg::st_fetch;
				end else if (is_load || is_store) begin
					state_nxt = rv_pkg::st_mem;
				end else begin
					state_nxt = rv_pkg::st_dest;
				end
			end
			rv_pkg::st_mem: state_nxt = rv_pkg::st_dest;
			default: state_nxt = rv_pkg::st_fetch;
		endcase
	end

	// state and pc
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= rv_pkg::st_fetch;
			pc <= '0;
		end else begin
			state <= state_nxt;
			if (state == rv_pkg::st_fetch) begin
				pc <= pc + rv_pkg::instr_bytes;
			end else if (state == rv_pkg::st_execute && i_br.taken) begin
				pc <= i_br.target;
			end
		end
	end

	// execute results held for mem and dest
	always_ff @(posedge clk) begin
		if (state == rv_pkg::st_execute) begin
			result_q <= i_result;
			ls_addr_q <= i_ops.rs1_val + i_dec.imm;
			st_data_q <= i_ops.rs2_val;
		end
		// load data comes back in the same cycle as the pulse
		if (o_ld) begin
			ld_q <= i_ld_data;
		end
	end

	assign o_fetch = state == rv_pkg::st_fetch;
	assign o_pc_addr = pc;
	// ir captures on the same edge the pc steps
	assign o_load_ir = o_fetch;
	assign o_ld = state == rv_pkg::st_mem && is_load;
	assign o_st = state == rv_pkg::st_mem && is_store;
	assign o_ls_addr = ls_addr_q;
	assign o_st_data = st_data_q;
	assign o_rf_we = state == rv_pkg::st_dest && writes_rd;
	// writeback select
	assign o_rf_data = is_load ? ld_q : result_q;

	a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
		o_ld |-> !o_st);

endmodule

`default_nettype wire

// ==== hw/rv_io_top.sv ====
`default_nettype none

module rv_io_top (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic [rv_pkg::xlen-1:0]  i_instr,
	input  wire logic [rv_pkg::led_w-1:0] i_sw,
	output logic                          o_fetch,
	output logic [rv_pkg::xlen-1:0]       o_pc_addr,
	output logic [rv_pkg::led_w-1:0]      o_led
);

	rv_pkg::decoded_t dec;
	rv_pkg::operands_t ops;
	rv_pkg::branch_t br;
	logic [rv_pkg::xlen-1:0] alu_result;
	logic [rv_pkg::xlen-1:0] ld_data;
	logic [rv_pkg::xlen-1:0] ls_addr;
	logic [rv_pkg::xlen-1:0] st_data;
	logic [rv_pkg::xlen-1:0] rf_data;
	logic load_ir;
	logic ld;
	logic st;
	logic rf_we;
	logic is_io;
	logic [rv_pkg::led_w-1:0] sw_q;
	logic [rv_pkg::led_w-1:0] led_q;

	rv_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.i_load_ir (load_ir),
		.i_instr   (i_instr),
		.o_dec     (dec)
	);

	rv_regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.i_dec     (dec),
		.i_we      (rf_we),
		.i_wr_data (rf_data),
		.o_ops     (ops)
	);

	// alu and branch evaluate side by side
	rv_alu u_alu (
		.i_dec    (dec),
		.i_ops    (ops),
		.o_result (alu_result)
	);

	rv_branch u_branch (
		.i_dec (dec),
		.i_ops (ops),
		.i_pc  (o_pc_addr),
		.o_br  (br)
	);

	rv_control u_control (
		.clk       (clk),
		.reset     (reset),
		.i_dec     (dec),
		.i_ops     (ops),
		.i_result  (alu_result),
		.i_br      (br),
		.i_ld_data (ld_data),
		.o_fetch   (o_fetch),
		.o_pc_addr (o_pc_addr),
		.o_load_ir (load_ir),
		.o_ld      (ld),
		.o_st      (st),
		.o_ls_addr (ls_addr),
		.o_st_data (st_data),
		.o_rf_we   (rf_we),
		.o_rf_data (rf_data)
	);

	// only one mapped word, everything else reads zero
	assign is_io = ls_addr == rv_pkg::io_addr;
	assign ld_data = (ld && is_io) ?
		{{(rv_pkg::xlen - rv_pkg::led_w){1'b0}}, sw_q} : '0;

	// switches sampled every cycle, leds on store to io_addr
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sw_q <= '0;
			led_q <= '0;
		end else begin
			sw_q <= i_sw;
			if (st && is_io) begin
				// low byte of the store word
				led_q <= st_data[rv_pkg::led_w-1:0];
			end
		end
	end

	assign o_led = led_q;

endmodule

`default_nettype wire

// ==== test/tb_rv_io_top.sv ====
`default_nettype none

module tb_rv_io_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_rows = 35;
	// addi x0, x0, 0
	localparam logic [31:0] nop = 32'h0000_0013;

	// kind of instruction placed in program slot 3
	typedef enum logic [1:0] {
		cls_r,
		cls_i,
		cls_lui,
		cls_br
	} row_class_e;

	typedef struct packed {
		row_class_e cls;
		logic [2:0] funct3;
		logic alt;
		// low 12 bits for addi and i type, all 20 for lui
		logic [19:0] imm;
		logic [7:0] sw;
		logic [7:0] led;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic [rv_pkg::xlen-1:0] i_instr;
	logic [rv_pkg::led_w-1:0] i_sw;
	logic o_fetch;
	logic [rv_pkg::xlen-1:0] o_pc_addr;
	logic [rv_pkg::led_w-1:0] o_led;

	row_t rows [n_rows];
	int n_fill = 0;
	logic [31:0] prog [6];

	rv_io_top dut (
		.clk       (clk),
		.reset     (reset),
		.i_instr   (i_instr),
		.i_sw      (i_sw),
		.o_fetch   (o_fetch),
		.o_pc_addr (o_pc_addr),
		.o_led     (o_led)
	);

	always #10 clk = ~clk;

	// instruction rom, nop past the end of the program
	always @(negedge clk) begin
		if (o_fetch) begin
			i_instr <= (o_pc_addr < 32'd24) ? prog[o_pc_addr[4:2]] : nop;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input row_class_e cls, input logic [2:0] f3, input logic alt,
		input logic [19:0] imm, input logic [7:0] sw, input logic [7:0] led);
		rows[n_fill] = '{cls, f3, alt, imm, sw, led};
		n_fill++;
	endtask

	// expected led is the low byte of x4, after the +1 unless a branch skipped it
	task automatic fill_table();
		add_row(cls_r, 3'd0, 1'b0, 20'h00005, 8'h10, 8'h16);
		add_row(cls_r, 3'd0, 1'b1, 20'h00003, 8'h10, 8'h0e);
		add_row(cls_r, 3'd1, 1'b0, 20'h00002, 8'h21, 8'h85);
		// x2 is -1
		add_row(cls_r, 3'd2, 1'b0, 20'h00fff, 8'h05, 8'h01);
		add_row(cls_r, 3'd3, 1'b0, 20'h00fff, 8'h05, 8'h02);
		add_row(cls_r, 3'd4, 1'b0, 20'h000f0, 8'hff, 8'h10);
		add_row(cls_r, 3'd5, 1'b0, 20'h00004, 8'h80, 8'h09);
		add_row(cls_r, 3'd5, 1'b1, 20'h00001, 8'hff, 8'h80);
		add_row(cls_r, 3'd6, 1'b0, 20'h0000f, 8'h80, 8'h90);
		add_row(cls_r, 3'd7, 1'b0, 20'h0003c, 8'hff, 8'h3d);
		// addi -3 and -1, the second wraps to zero
		add_row(cls_i, 3'd0, 1'b0, 20'h00ffd, 8'h10, 8'h0e);
		add_row(cls_i, 3'd0, 1'b0, 20'h00fff, 8'h00, 8'h00);
		add_row(cls_i, 3'd1, 1'b0, 20'h00003, 8'h11, 8'h89);
		add_row(cls_i, 3'd2, 1'b0, 20'h00ffe, 8'h80, 8'h01);
		add_row(cls_i, 3'd2, 1'b0, 20'h007ff, 8'h80, 8'h02);
		add_row(cls_i, 3'd3, 1'b0, 20'h00ffe, 8'hff, 8'h02);
		add_row(cls_i, 3'd3, 1'b0, 20'h00010, 8'hff, 8'h01);
		add_row(cls_i, 3'd4, 1'b0, 20'h00fff, 8'h0f, 8'hf1);
		add_row(cls_i, 3'd5, 1'b0, 20'h00003, 8'hff, 8'h20);
		// srai
		add_row(cls_i, 3'd5, 1'b1, 20'h00002, 8'h80, 8'h21);
		add_row(cls_i, 3'd6, 1'b0, 20'h00f00, 8'h80, 8'h81);
		add_row(cls_i, 3'd7, 1'b0, 20'h000f0, 8'hff, 8'hf1);
		add_row(cls_lui, 3'd0, 1'b0, 20'h12345, 8'h55, 8'h01);
		// branches on x1 = sw and x2 = imm, taken leaves x4 at 0
		add_row(cls_br, 3'd0, 1'b0, 20'h00080, 8'h80, 8'h00);
		add_row(cls_br, 3'd0, 1'b0, 20'h0007f, 8'h80, 8'h01);
		add_row(cls_br, 3'd1, 1'b0, 20'h0007f, 8'h80, 8'h00);
		add_row(cls_br, 3'd1, 1'b0, 20'h00000, 8'h00, 8'h01);
		add_row(cls_br, 3'd4, 1'b0, 20'h00fff, 8'h00, 8'h01);
		add_row(cls_br, 3'd4, 1'b0, 20'h00001, 8'h00, 8'h00);
		add_row(cls_br, 3'd5, 1'b0, 20'h00fff, 8'h00, 8'h00);
		add_row(cls_br, 3'd5, 1'b0, 20'h00100, 8'hff, 8'h01);
		add_row(cls_br, 3'd6, 1'b0, 20'h00fff, 8'hff, 8'h00);
		add_row(cls_br, 3'd6, 1'b0, 20'h00010, 8'hff, 8'h01);
		add_row(cls_br, 3'd7, 1'b0, 20'h00fff, 8'h00, 8'h01);
		add_row(cls_br, 3'd7, 1'b0, 20'h00000, 8'h00, 8'h00);
	endtask

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	// slot 3, writes x4 or branches on x1 and x2
	function automatic logic [31:0] row_instr(input row_t r);
		logic [11:0] imm12;
		imm12 = r.imm[11:0];
		// shifts carry alt in bit 30 and shamt in the low bits
		if (r.funct3 == 3'd1 || r.funct3 == 3'd5) begin
			imm12 = {1'b0, r.alt, 5'b0, r.imm[4:0]};
		end
		case (r.cls)
			cls_r: return {1'b0, r.alt, 5'b0, 5'd2, 5'd1, r.funct3, 5'd4, 7'b0110011};
			cls_i: return {imm12, 5'd1, r.funct3, 5'd4, 7'b0010011};
			cls_lui: return {r.imm, 5'd4, 7'b0110111};
			// offset 8 lands on the store, imm[4:1] = 4
			default: return {7'b0, 5'd2, 5'd1, r.funct3, 5'b01000, 7'b1100011};
		endcase
	endfunction

	// cycles from reset release to the fetch at 0x14
	function automatic int cycles_to_store(input row_t r);
		int n;
		// lui, lw and addi x2
		n = 4 + 5 + 4;
		if (r.cls != cls_br) begin
			n += 4 + 4;
		end else if (r.led != 8'h00) begin
			// branch falls through to addi x4
			n += 3 + 4;
		end else begin
			n += 3;
		end
		return n;
	endfunction

	// counts falling edges until the fetch of addr
	task automatic wait_fetch(input logic [31:0] addr, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!(o_fetch && o_pc_addr == addr));
	endtask

	initial begin
		row_t r;
		int cycles;
		reset = 1'b1;
		i_sw = '0;
		i_instr = nop;
		fill_table();
		for (int n = 0; n < n_rows; n++) begin
			r = rows[n];
			@(negedge clk);
			reset = 1'b1;
			i_sw = r.sw;
			// x3 = io_addr, x1 = switches, x2 = row immediate
			prog[0] = {20'h0000a, 5'd3, 7'b0110111};
			prog[1] = {12'h000, 5'd3, 3'b010, 5'd1, 7'b0000011};
			prog[2] = addi_word(5'd2, 5'd0, r.imm[11:0]);
			prog[3] = row_instr(r);
			prog[4] = addi_word(5'd4, 5'd4, 12'd1);
			// sw x4 to io_addr
			prog[5] = {7'b0, 5'd4, 5'd3, 3'b010, 5'b0, 7'b0100011};
			repeat (4) @(negedge clk);
			reset = 1'b0;
			// nothing stored yet
			wait_fetch(32'd20, cycles);
			check_value("o_led", o_led, 8'h00);
			check_value("fetch cycle of o_pc_addr 0x14", cycles, cycles_to_store(r));
			wait_fetch(32'd24, cycles);
			check_value("o_led", o_led, r.led);
			// store runs through all five states
			check_value("fetch cycle of o_pc_addr 0x18", cycles, 5);
		end
		$display("PASS: all tests");
		$finish;
	end

	// about 32 cycles per row, doubled
	initial begin
		#(n_rows * 32 * 20 * 2);
		$display("timeout: the core never fetched the end of the program");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== flist.f ====
common/rv_pkg.sv
core/rv_decode.sv
core/rv_regfile.sv
core/rv_alu.sv
core/rv_branch.sv
core/rv_control.sv
hw/rv_io_top.sv
test/tb_rv_io_top.sv

// ==== Bender.yml ====
package:
  name: rv_io

sources:
  - common/rv_pkg.sv
  - core/rv_decode.sv
  - core/rv_regfile.sv
  - core/rv_alu.sv
  - core/rv_branch.sv
  - core/rv_control.sv
  - hw/rv_io_top.sv
  - target: test
    files:
      - test/tb_rv_io_top.sv
